//--- rv32_pkg.sv
package rv32_pkg;

  // basic data and index types
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // all-ones word stops the core
  parameter word_t HALT_WORD = 32'hffff_ffff;

  // major opcodes used by this core
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  // funct3 of loads, reused as store width
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_type_t;

  // funct3 of branches
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_type_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  // write-back source
  typedef enum logic [1:0] {
    W_LOAD, W_PC4, W_IMM_U, W_ALU
  } w_sel_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_ex_t;

  typedef struct packed {
    alu_op_t      alu_op;
    // a: 0 rs1, 1 pc
    logic         alu_a_sel;
    // b: 0 rs2, 1 imm_i, 2 imm_s, 3 imm_u
    logic [1:0]   alu_b_sel;
    w_sel_t       w_sel;
    logic         wen;
    logic         dren;
    logic         dwen;
    load_type_t   load_type;
    logic         branch;
    branch_type_t branch_type;
    logic         jump;
    // 1 selects jal target, 0 jalr
    logic         j_sel;
    logic         halt;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_sb;
    word_t        imm_uj;
    word_t        imm_u;
  } ctrl_t;

  typedef struct packed {
    logic       ren;
    logic       wen;
    word_t      addr;
    logic [3:0] byte_en;
    word_t      wdata;
  } dmem_req_t;

endpackage

//--- control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
  input  rv32_pkg::word_t instr,
  output rv32_pkg::ctrl_t ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  // funct7 bit 5 picks sub and sra
  assign alt    = instr[30];

  // maps funct3 of op and op-imm onto an alu operation
  function automatic rv32_pkg::alu_op_t f3_op(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  f3_op = sub_sra ? rv32_pkg::SUB : rv32_pkg::ADD;
      3'b001:  f3_op = rv32_pkg::SLL;
      3'b010:  f3_op = rv32_pkg::SLT;
      3'b011:  f3_op = rv32_pkg::SLTU;
      3'b100:  f3_op = rv32_pkg::XOR;
      3'b101:  f3_op = sub_sra ? rv32_pkg::SRA : rv32_pkg::SRL;
      3'b110:  f3_op = rv32_pkg::OR;
      default: f3_op = rv32_pkg::AND;
    endcase
  endfunction

  always_comb begin
    // everything off by default, so unknown opcodes do nothing
    ctrl = '0;
    ctrl.alu_op = rv32_pkg::ADD;
    ctrl.w_sel  = rv32_pkg::W_ALU;
    ctrl.rs1    = instr[19:15];
    ctrl.rs2    = instr[24:20];
    ctrl.rd     = instr[11:7];
    // immediates, all sign extended where the format says so
    ctrl.imm_i  = {{20{instr[31]}}, instr[31:20]};
    ctrl.imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_sb = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_uj = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_u  = {instr[31:12], 12'b0};

    if (instr == rv32_pkg::HALT_WORD) begin
      ctrl.halt = 1'b1;
    end else begin
      case (opcode)
        rv32_pkg::OP_LUI: begin
          ctrl.wen   = 1'b1;
          ctrl.w_sel = rv32_pkg::W_IMM_U;
        end
        rv32_pkg::OP_AUIPC: begin
          // pc + imm_u through the alu
          ctrl.wen       = 1'b1;
          ctrl.alu_a_sel = 1'b1;
          ctrl.alu_b_sel = 2'd3;
        end
        rv32_pkg::OP_JAL, rv32_pkg::OP_JALR: begin
          ctrl.wen   = 1'b1;
          ctrl.w_sel = rv32_pkg::W_PC4;
          ctrl.jump  = 1'b1;
          ctrl.j_sel = (opcode == rv32_pkg::OP_JAL);
        end
        rv32_pkg::OP_BRANCH: begin
          // funct3 010 and 011 are reserved
          ctrl.branch      = (funct3[2:1] != 2'b01);
          ctrl.branch_type = rv32_pkg::branch_type_t'(funct3);
        end
        rv32_pkg::OP_LOAD: begin
          ctrl.dren      = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
          ctrl.wen       = ctrl.dren;
          ctrl.w_sel     = rv32_pkg::W_LOAD;
          ctrl.alu_b_sel = 2'd1;
          ctrl.load_type = rv32_pkg::load_type_t'(funct3);
        end
        rv32_pkg::OP_STORE: begin
          // only sb, sh, sw
          ctrl.dwen      = (funct3[2] == 1'b0) && (funct3 != 3'b011);
          ctrl.alu_b_sel = 2'd2;
          ctrl.load_type = rv32_pkg::load_type_t'(funct3);
        end
        rv32_pkg::OP_IMM: begin
          ctrl.wen       = 1'b1;
          ctrl.alu_b_sel = 2'd1;
          // bit 30 is an immediate bit except for srai
          ctrl.alu_op    = f3_op(funct3, alt && (funct3 == 3'b101));
        end
        rv32_pkg::OP_REG: begin
          ctrl.wen    = 1'b1;
          ctrl.alu_op = f3_op(funct3, alt);
        end
        default: ;
      endcase
    end
  end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
  input  rv32_pkg::alu_op_t alu_op,
  input  rv32_pkg::word_t   port_a,
  input  rv32_pkg::word_t   port_b,
  output rv32_pkg::word_t   port_out
);

  logic [4:0] shamt;

  // only the low five bits count for shifts
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      rv32_pkg::ADD:  port_out = port_a + port_b;
      rv32_pkg::SUB:  port_out = port_a - port_b;
      rv32_pkg::SLL:  port_out = port_a << shamt;
      // signed compare
      rv32_pkg::SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      rv32_pkg::SLTU: port_out = {31'b0, port_a < port_b};
      rv32_pkg::XOR:  port_out = port_a ^ port_b;
      rv32_pkg::SRL:  port_out = port_a >> shamt;
      // arithmetic shift keeps the sign bit
      rv32_pkg::SRA:  port_out = $signed(port_a) >>> shamt;
      rv32_pkg::OR:   port_out = port_a | port_b;
      rv32_pkg::AND:  port_out = port_a & port_b;
      default:        port_out = '0;
    endcase
  end

endmodule

//--- branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
  input  rv32_pkg::word_t rs1_data,
  input  rv32_pkg::word_t rs2_data,
  input  rv32_pkg::word_t pc,
  input  rv32_pkg::ctrl_t ctrl,
  output logic            taken,
  output rv32_pkg::word_t target
);

  logic eq;
  logic lt;
  logic ltu;
  logic cond;
  rv32_pkg::word_t jalr_sum;

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  // condition for the branch type
  always_comb begin
    case (ctrl.branch_type)
      rv32_pkg::BEQ:  cond = eq;
      rv32_pkg::BNE:  cond = !eq;
      rv32_pkg::BLT:  cond = lt;
      rv32_pkg::BGE:  cond = !lt;
      rv32_pkg::BLTU: cond = ltu;
      rv32_pkg::BGEU: cond = !ltu;
      default:        cond = 1'b0;
    endcase
  end

  // jumps always leave the fall-through path
  assign taken = ctrl.jump || (ctrl.branch && cond);

  assign jalr_sum = rs1_data + ctrl.imm_i;

  always_comb begin
    if (ctrl.jump && ctrl.j_sel) begin
      target = pc + ctrl.imm_uj;
    end else if (ctrl.jump) begin
      // jalr drops bit 0
      target = {jalr_sum[31:1], 1'b0};
    end else begin
      target = pc + ctrl.imm_sb;
    end
  end

endmodule

//--- rv32_reg_file.sv
`timescale 1ns/1ps

module rv32_reg_file (
  input  logic               CLK,
  input  logic               arst_n,
  input  rv32_pkg::reg_addr_t rs1,
  input  rv32_pkg::reg_addr_t rs2,
  input  rv32_pkg::reg_addr_t rd,
  input  logic               wen,
  input  rv32_pkg::word_t     w_data,
  output rv32_pkg::word_t     rs1_data,
  output rv32_pkg::word_t     rs2_data
);

  // x0 has no storage
  rv32_pkg::word_t regs [1:31];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= w_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                CLK,
  input  logic                arst_n,
  input  rv32_pkg::fetch_ex_t fetch_ex,
  output logic                redirect,
  output rv32_pkg::word_t     brj_addr,
  output logic                stall,
  output rv32_pkg::dmem_req_t dmem_req,
  input  rv32_pkg::word_t     dmem_rdata,
  input  logic                dmem_busy,
  output logic                halt
);

  rv32_pkg::ctrl_t ctrl;
  rv32_pkg::word_t rs1_data;
  rv32_pkg::word_t rs2_data;
  rv32_pkg::word_t alu_a;
  rv32_pkg::word_t alu_b;
  rv32_pkg::word_t alu_out;
  rv32_pkg::word_t w_data;
  rv32_pkg::word_t load_shift;
  rv32_pkg::word_t load_ext;
  logic            taken;
  logic            active;
  logic            mem_op;
  logic            rf_wen;
  logic [1:0]      byte_off;
  logic [3:0]      byte_en;

  control_decoder u_dec (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  rv32_reg_file u_rf (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .wen      (rf_wen),
    .w_data   (w_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .alu_op   (ctrl.alu_op),
    .port_a   (alu_a),
    .port_b   (alu_b),
    .port_out (alu_out)
  );

  // runs next to the alu and not behind it
  branch_resolver u_br (
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (fetch_ex.pc),
    .ctrl     (ctrl),
    .taken    (taken),
    .target   (brj_addr)
  );

  // live instruction in this stage
  assign active = fetch_ex.valid && !halt;
  assign mem_op = active && (ctrl.dren || ctrl.dwen);

  // the not-taken guess means any taken transfer flushes
  assign redirect = active && taken;
  // hold fetch until the access completes and forever after halt
  assign stall    = halt || (mem_op && dmem_busy);

  assign alu_a = ctrl.alu_a_sel ? fetch_ex.pc : rs1_data;

  always_comb begin
    case (ctrl.alu_b_sel)
      2'd0:    alu_b = rs2_data;
      2'd1:    alu_b = ctrl.imm_i;
      2'd2:    alu_b = ctrl.imm_s;
      default: alu_b = ctrl.imm_u;
    endcase
  end

  assign byte_off = alu_out[1:0];

  // byte lanes touched by the access, decoded from the shared funct3
  always_comb begin
    case (ctrl.load_type)
      rv32_pkg::LB, rv32_pkg::LBU: byte_en = 4'b0001 << byte_off;
      rv32_pkg::LH, rv32_pkg::LHU: begin
        case (byte_off)
          2'b00:   byte_en = 4'b0011;
          2'b10:   byte_en = 4'b1100;
          default: byte_en = 4'b0000;
        endcase
      end
      default: byte_en = 4'b1111;
    endcase
  end

  always_comb begin
    dmem_req.ren     = active && ctrl.dren;
    dmem_req.wen     = active && ctrl.dwen;
    dmem_req.addr    = alu_out;
    dmem_req.byte_en = byte_en;
    // store data is copied to every lane and byte_en picks the right one
    case (ctrl.load_type)
      rv32_pkg::LB: dmem_req.wdata = {4{rs2_data[7:0]}};
      rv32_pkg::LH: dmem_req.wdata = {2{rs2_data[15:0]}};
      default:      dmem_req.wdata = rs2_data;
    endcase
  end

  // move the addressed lane down to bit 0
  assign load_shift = dmem_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (ctrl.load_type)
      rv32_pkg::LB:  load_ext = {{24{load_shift[7]}}, load_shift[7:0]};
      rv32_pkg::LBU: load_ext = {24'b0, load_shift[7:0]};
      rv32_pkg::LH:  load_ext = {{16{load_shift[15]}}, load_shift[15:0]};
      rv32_pkg::LHU: load_ext = {16'b0, load_shift[15:0]};
      default:       load_ext = dmem_rdata;
    endcase
  end

  always_comb begin
    case (ctrl.w_sel)
      rv32_pkg::W_LOAD:  w_data = load_ext;
      rv32_pkg::W_PC4:   w_data = fetch_ex.pc4;
      rv32_pkg::W_IMM_U: w_data = ctrl.imm_u;
      default:           w_data = alu_out;
    endcase
  end

  // loads write in the cycle the access completes
  assign rf_wen = active && ctrl.wen && !(mem_op && dmem_busy);

  // sticky until reset
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      halt <= 1'b0;
    end else if (active && ctrl.halt) begin
      halt <= 1'b1;
    end
  end

  a_rw_excl: assert property (@(posedge CLK) disable iff (!arst_n)
    !(dmem_req.ren && dmem_req.wen));

  a_byte_en: assert property (@(posedge CLK) disable iff (!arst_n)
    (dmem_req.ren || dmem_req.wen) |-> (dmem_req.byte_en != 4'b0000));

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter rv32_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                CLK,
  input  logic                arst_n,
  output rv32_pkg::word_t     imem_addr,
  input  rv32_pkg::word_t     imem_rdata,
  input  logic                redirect,
  input  rv32_pkg::word_t     brj_addr,
  input  logic                stall,
  output rv32_pkg::fetch_ex_t fetch_ex
);

  rv32_pkg::word_t pc;
  rv32_pkg::word_t pc_plus4;

  assign pc_plus4  = pc + 32'd4;
  // instruction memory answers in the same cycle
  assign imem_addr = pc;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= RESET_PC;
      fetch_ex <= '0;
    end else if (redirect) begin
      // redirect wins over stall, the fetched word is dropped
      pc             <= brj_addr;
      fetch_ex.valid <= 1'b0;
    end else if (!stall) begin
      pc       <= pc_plus4;
      fetch_ex <= '{valid: 1'b1, instr: imem_rdata, pc: pc, pc4: pc_plus4};
    end
  end

  a_pc_aligned: assert property (@(posedge CLK) disable iff (!arst_n)
    pc[1:0] == 2'b00);

endmodule

//--- rv32_core.sv
`timescale 1ns/1ps

module rv32_core #(
  parameter rv32_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                CLK,
  input  logic                arst_n,
  output rv32_pkg::word_t     imem_addr,
  input  rv32_pkg::word_t     imem_rdata,
  output rv32_pkg::dmem_req_t dmem_req,
  input  rv32_pkg::word_t     dmem_rdata,
  input  logic                dmem_busy,
  output logic                halt
);

  rv32_pkg::fetch_ex_t fetch_ex;
  rv32_pkg::word_t     brj_addr;
  logic                redirect;
  logic                stall;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .redirect   (redirect),
    .brj_addr   (brj_addr),
    .stall      (stall),
    .fetch_ex   (fetch_ex)
  );

  // decode, operands, alu and branch work all happen here
  execute_stage u_exec (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .fetch_ex   (fetch_ex),
    .redirect   (redirect),
    .brj_addr   (brj_addr),
    .stall      (stall),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .dmem_busy  (dmem_busy),
    .halt       (halt)
  );

endmodule

//--- tb_rv32_core.sv
`timescale 1ns/1ps

module tb_rv32_core;

  logic                CLK = 1'b0;
  logic                arst_n;
  rv32_pkg::word_t     imem_addr;
  rv32_pkg::word_t     imem_rdata;
  rv32_pkg::dmem_req_t dmem_req;
  rv32_pkg::word_t     dmem_rdata;
  logic                dmem_busy;
  logic                halt;

  // program image and byte-lane data memory
  rv32_pkg::word_t prog [0:255];
  int              prog_len;
  logic [7:0]      dmem [0:2047];
  // expected memory image built from the store rules
  logic [7:0]      ref_mem [0:2047];

  // memory model state
  logic        mem_req;
  logic        in_access;
  logic        slow_mem;
  int          wait_left;
  int          write_count;
  int          busy_cycles;
  logic [31:0] rng;

  // bookkeeping for programs and checks
  rv32_pkg::word_t exp_addr [$];
  rv32_pkg::word_t exp_val [$];
  rv32_pkg::word_t next_result;
  int              store_count;
  int              errors;
  int              errors_at_start;
  int              tests_run;
  int              tests_failed;

  rv32_core UUT (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .dmem_busy  (dmem_busy),
    .halt       (halt)
  );

  always #5 CLK = ~CLK;

  // combinational instruction read that returns halt past the program end
  assign imem_rdata = (imem_addr[31:2] < prog_len) ? prog[imem_addr[9:2]]
                                                   : rv32_pkg::HALT_WORD;
  assign mem_req    = dmem_req.ren || dmem_req.wen;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 3) ^ 8'h5a;
  endfunction

  function automatic rv32_pkg::word_t read_word(input rv32_pkg::word_t addr);
    int b;
    b = {addr[10:2], 2'b00};
    return {dmem[b + 3], dmem[b + 2], dmem[b + 1], dmem[b]};
  endfunction

  function automatic rv32_pkg::word_t ref_word(input rv32_pkg::word_t addr);
    int b;
    b = {addr[10:2], 2'b00};
    return {ref_mem[b + 3], ref_mem[b + 2], ref_mem[b + 1], ref_mem[b]};
  endfunction

  // a new access picks its busy delay and counts down one per cycle
  always @(negedge CLK) begin
    if (arst_n && mem_req) begin
      if (!in_access) begin
        in_access = 1'b1;
        if (slow_mem) begin
          rng = xorshift32(rng);
          wait_left = rng[1:0];
        end else begin
          wait_left = 0;
        end
      end else if (wait_left != 0) begin
        wait_left = wait_left - 1;
      end
      if (wait_left != 0) begin
        busy_cycles++;
      end
      dmem_busy  <= (wait_left != 0);
      dmem_rdata <= read_word(dmem_req.addr);
    end else begin
      dmem_busy <= 1'b0;
    end
  end

  // access completes at the edge where the request sees busy low
  always @(posedge CLK) begin
    if (arst_n && mem_req && in_access && !dmem_busy) begin
      if (dmem_req.wen) begin
        for (int i = 0; i < 4; i++) begin
          if (dmem_req.byte_en[i]) begin
            dmem[{dmem_req.addr[10:2], 2'b00} + i] = dmem_req.wdata[8*i +: 8];
          end
        end
        write_count++;
      end
      in_access = 1'b0;
    end
  end

  // instruction encoders
  function automatic rv32_pkg::word_t enc_r(input logic [6:0] f7,
      input rv32_pkg::reg_addr_t rs2, rs1, input logic [2:0] f3, input rv32_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv32_pkg::word_t enc_i(input logic [11:0] imm,
      input rv32_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv32_pkg::reg_addr_t rd,
      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32_pkg::word_t enc_s(input logic [11:0] imm,
      input rv32_pkg::reg_addr_t rs2, rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv32_pkg::word_t enc_b(input logic [12:0] imm,
      input rv32_pkg::reg_addr_t rs2, rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv32_pkg::word_t enc_u(input logic [19:0] imm,
      input rv32_pkg::reg_addr_t rd, input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv32_pkg::word_t enc_j(input logic [20:0] imm,
      input rv32_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // branch conditions straight from the isa
  function automatic logic branch_rule(input logic [2:0] f3, input rv32_pkg::word_t a, b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input rv32_pkg::word_t instr);
    prog[prog_len] = instr;
    prog_len++;
  endtask

  // lui then addi with the upper part rounded for the sign of the low twelve bits
  task automatic load_imm(input rv32_pkg::reg_addr_t rd, input rv32_pkg::word_t v);
    emit(enc_u(v[31:12] + v[11], rd, 7'h37));
    emit(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  task automatic store_word(input rv32_pkg::reg_addr_t rs2, input rv32_pkg::word_t addr);
    emit(enc_s(addr[11:0], rs2, 5'd0, 3'd2));
    store_count++;
  endtask

  task automatic push_expect(input rv32_pkg::word_t addr, input rv32_pkg::word_t val);
    exp_addr.push_back(addr);
    exp_val.push_back(val);
  endtask

  task automatic alu_result(input rv32_pkg::word_t instr, input rv32_pkg::word_t exp);
    emit(instr);
    store_word(5'd3, next_result);
    push_expect(next_result, exp);
    next_result += 4;
  endtask

  // sub-word store that places the little-endian lanes in ref_mem
  task automatic store_sub(input logic [2:0] f3, input rv32_pkg::word_t addr,
      input rv32_pkg::word_t value);
    int nbytes;
    nbytes = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
    load_imm(5'd5, value);
    emit(enc_s(addr[11:0], 5'd5, 5'd0, f3));
    store_count++;
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[addr[10:0] + i] = value[8*i +: 8];
    end
  endtask

  // load then store the register with the expected value extended by funct3
  task automatic load_sub(input logic [2:0] f3, input rv32_pkg::word_t addr);
    rv32_pkg::word_t w;
    logic [7:0]      b0;
    logic [7:0]      b1;
    b0 = ref_mem[addr[10:0]];
    b1 = ref_mem[addr[10:0] + 1];
    emit(enc_i(addr[11:0], 5'd0, f3, 5'd6, 7'h03));
    store_word(5'd6, next_result);
    case (f3)
      3'd0:    w = {{24{b0[7]}}, b0};
      3'd4:    w = {24'b0, b0};
      3'd1:    w = {{16{b1[7]}}, b1, b0};
      3'd5:    w = {16'b0, b1, b0};
      default: w = ref_word(addr);
    endcase
    push_expect(next_result, w);
    next_result += 4;
  endtask

  task automatic begin_test();
    prog_len    = 0;
    store_count = 0;
    write_count = 0;
    busy_cycles = 0;
    next_result = 32'h100;
    exp_addr.delete();
    exp_val.delete();
    for (int i = 0; i < 2048; i++) begin
      dmem[i]    = fill_byte(i);
      ref_mem[i] = fill_byte(i);
    end
    errors_at_start = errors;
  endtask

  // while held in reset the core points at the reset pc and issues nothing
  task automatic check_reset_state();
    assert (imem_addr === 32'h0000_0000 && halt === 1'b0 && mem_req === 1'b0) else begin
      $display("FAILED %0t: in reset imem_addr 0x%08h halt %b request %b",
               $time, imem_addr, halt, mem_req);
      errors++;
    end
  endtask

  task automatic reset_dut();
    @(negedge CLK);
    arst_n <= 1'b0;
    in_access = 1'b0;
    repeat (16) @(negedge CLK);
    check_reset_state();
    arst_n <= 1'b1;
  endtask

  task automatic wait_halt(input string name);
    int n;
    n = 0;
    while (!halt && n < 2000) begin
      @(negedge CLK);
      n++;
    end
    if (!halt) begin
      $display("%s: halt never arrived within 2000 cycles", name);
      errors++;
    end
  endtask

  task automatic run_program(input string name);
    emit(rv32_pkg::HALT_WORD);
    reset_dut();
    wait_halt(name);
  endtask

  task automatic check_word(input rv32_pkg::word_t addr, input rv32_pkg::word_t exp);
    rv32_pkg::word_t got;
    got = read_word(addr);
    assert (got === exp) else begin
      $display("FAILED %0t: word at 0x%08h is 0x%08h, expected 0x%08h",
               $time, addr, got, exp);
      errors++;
    end
  endtask

  task automatic check_expected();
    foreach (exp_addr[i]) begin
      check_word(exp_addr[i], exp_val[i]);
    end
  endtask

  task automatic check_write_count();
    assert (write_count == store_count) else begin
      $display("FAILED %0t: %0d writes completed, expected %0d", $time, write_count, store_count);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_at_start);
    end
  endtask

  task automatic test_alu();
    rv32_pkg::word_t a;
    rv32_pkg::word_t b;
    rv32_pkg::word_t imm;
    begin_test();
    for (int r = 0; r < 3; r++) begin
      rng = xorshift32(rng);
      a   = rng;
      rng = xorshift32(rng);
      b   = rng;
      rng = xorshift32(rng);
      imm = {{20{rng[11]}}, rng[11:0]};
      load_imm(5'd1, a);
      load_imm(5'd2, b);
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), a + b);
      alu_result(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3), a - b);
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd3), a ^ b);
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd3), a | b);
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd3), a & b);
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd3), a << b[4:0]);
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd3), a >> b[4:0]);
      alu_result(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3), $signed(a) >>> b[4:0]);
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3), {31'b0, $signed(a) < $signed(b)});
      alu_result(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd3), {31'b0, a < b});
      // immediate forms where imm is already sign extended
      alu_result(enc_i(imm[11:0], 5'd1, 3'd0, 5'd3, 7'h13), a + imm);
      alu_result(enc_i(imm[11:0], 5'd1, 3'd2, 5'd3, 7'h13), {31'b0, $signed(a) < $signed(imm)});
      alu_result(enc_i(imm[11:0], 5'd1, 3'd3, 5'd3, 7'h13), {31'b0, a < imm});
      alu_result(enc_i(imm[11:0], 5'd1, 3'd4, 5'd3, 7'h13), a ^ imm);
      alu_result(enc_i(imm[11:0], 5'd1, 3'd6, 5'd3, 7'h13), a | imm);
      alu_result(enc_i(imm[11:0], 5'd1, 3'd7, 5'd3, 7'h13), a & imm);
      alu_result(enc_i({7'h00, imm[4:0]}, 5'd1, 3'd1, 5'd3, 7'h13), a << imm[4:0]);
      alu_result(enc_i({7'h00, imm[4:0]}, 5'd1, 3'd5, 5'd3, 7'h13), a >> imm[4:0]);
      alu_result(enc_i({7'h20, imm[4:0]}, 5'd1, 3'd5, 5'd3, 7'h13), $signed(a) >>> imm[4:0]);
    end
    run_program("alu");
    check_expected();
    end_test("alu");
  endtask

  // byte and half stores and then every load form read back
  task automatic build_subword();
    store_sub(3'd0, 32'h200, 32'h0000_00f1);
    store_sub(3'd0, 32'h201, 32'h0000_0022);
    store_sub(3'd0, 32'h202, 32'h0000_0083);
    store_sub(3'd0, 32'h203, 32'h0000_007c);
    store_sub(3'd1, 32'h204, 32'h0000_8765);
    store_sub(3'd1, 32'h206, 32'h0000_4321);
    // upper bits of the register must not leak into memory
    store_sub(3'd1, 32'h20a, 32'h1234_9abc);
    store_sub(3'd0, 32'h209, 32'hffff_ff5e);
    for (int i = 0; i < 4; i++) begin
      load_sub(3'd0, 32'h200 + i);
      load_sub(3'd4, 32'h200 + i);
    end
    load_sub(3'd1, 32'h204);
    load_sub(3'd1, 32'h206);
    load_sub(3'd5, 32'h204);
    load_sub(3'd5, 32'h206);
    load_sub(3'd2, 32'h200);
    load_sub(3'd2, 32'h204);
    load_sub(3'd2, 32'h208);
    // whole store region where neighbours keep the fill
    for (int i = 0; i < 4; i++) begin
      push_expect(32'h200 + 4*i, ref_word(32'h200 + 4*i));
    end
  endtask

  task automatic test_subword();
    begin_test();
    build_subword();
    run_program("subword");
    check_expected();
    check_write_count();
    end_test("subword");
  endtask

  task automatic branch_case(input logic [2:0] f3, input rv32_pkg::word_t a, b);
    load_imm(5'd1, a);
    load_imm(5'd2, b);
    emit(enc_b(13'd8, 5'd2, 5'd1, f3));
    // marker only on the fall-through path
    store_word(5'd9, next_result);
    push_expect(next_result, branch_rule(f3, a, b) ? ref_word(next_result) : 32'h5a5a_a5a5);
    next_result += 4;
  endtask

  task automatic test_branches();
    logic [2:0] types [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    begin_test();
    load_imm(5'd9, 32'h5a5a_a5a5);
    // -3 and 2 split signed from unsigned order
    foreach (types[i]) begin
      branch_case(types[i], 32'hffff_fffd, 32'd2);
      branch_case(types[i], 32'd2, 32'hffff_fffd);
      branch_case(types[i], 32'd7, 32'd7);
    end
    load_imm(5'd10, 32'h600d_0001);
    store_word(5'd10, next_result);
    push_expect(next_result, 32'h600d_0001);
    run_program("branches");
    check_expected();
    end_test("branches");
  endtask

  task automatic test_jumps();
    rv32_pkg::word_t pc_j;
    rv32_pkg::word_t pc_r;
    rv32_pkg::word_t pc_a;
    begin_test();
    load_imm(5'd9, 32'hdead_0bad);
    pc_j = 4 * prog_len;
    emit(enc_j(21'd12, 5'd1));
    store_word(5'd9, 32'h318);
    store_word(5'd9, 32'h318);
    // jal target
    store_word(5'd1, 32'h300);
    push_expect(32'h300, pc_j + 4);
    load_imm(5'd10, 32'h7a60_0001);
    store_word(5'd10, 32'h304);
    push_expect(32'h304, 32'h7a60_0001);
    // li takes two words so jalr sits at pc_r + 8 and its target at pc_r + 16
    pc_r = 4 * prog_len;
    load_imm(5'd11, pc_r + 16);
    emit(enc_i(12'd1, 5'd11, 3'd0, 5'd12, 7'h67));
    store_word(5'd9, 32'h318);
    store_word(5'd12, 32'h308);
    push_expect(32'h308, pc_r + 12);
    load_imm(5'd10, 32'h7a60_0002);
    store_word(5'd10, 32'h30c);
    push_expect(32'h30c, 32'h7a60_0002);
    pc_a = 4 * prog_len;
    emit(enc_u(20'h12345, 5'd13, 7'h17));
    store_word(5'd13, 32'h310);
    push_expect(32'h310, pc_a + 32'h1234_5000);
    emit(enc_u(20'hfedcb, 5'd14, 7'h37));
    store_word(5'd14, 32'h314);
    push_expect(32'h314, 32'hfedc_b000);
    push_expect(32'h318, ref_word(32'h318));
    run_program("jumps");
    check_expected();
    end_test("jumps");
  endtask

  task automatic test_backpressure();
    begin_test();
    slow_mem = 1'b1;
    build_subword();
    run_program("backpressure");
    slow_mem = 1'b0;
    check_expected();
    check_write_count();
    assert (busy_cycles > 0) else begin
      $display("memory never held the core busy during the back-pressure run");
      errors++;
    end
    end_test("backpressure");
  endtask

  task automatic test_halt();
    begin_test();
    load_imm(5'd5, 32'hc0ff_ee11);
    store_word(5'd5, 32'h380);
    push_expect(32'h380, 32'hc0ff_ee11);
    emit(rv32_pkg::HALT_WORD);
    // never executed
    emit(enc_s(12'h384, 5'd5, 5'd0, 3'd2));
    emit(enc_s(12'h388, 5'd5, 5'd0, 3'd2));
    push_expect(32'h384, ref_word(32'h384));
    push_expect(32'h388, ref_word(32'h388));
    run_program("halt");
    repeat (50) begin
      @(negedge CLK);
      assert (halt && !mem_req) else begin
        $display("FAILED %0t: halt dropped or a memory request was active after halt", $time);
        errors++;
      end
    end
    check_expected();
    check_write_count();
    end_test("halt");
  endtask

  initial begin
    arst_n       = 1'b0;
    dmem_busy    = 1'b0;
    dmem_rdata   = '0;
    in_access    = 1'b0;
    slow_mem     = 1'b0;
    wait_left    = 0;
    rng          = 32'h9462_b765;
    prog_len     = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_alu();
    test_subword();
    test_branches();
    test_jumps();
    test_backpressure();
    test_halt();
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- rv32_core.f
rv32_pkg.sv
control_decoder.sv
alu.sv
branch_resolver.sv
rv32_reg_file.sv
execute_stage.sv
fetch_stage.sv
rv32_core.sv
tb_rv32_core.sv
